//--- hw/frontend_map.sv
/*
 * Frontend output mapping
 * DAC channel swap, hardware LED pattern from DSP activity and the
 * per-bit hardware or software LED mix
 */
`timescale 1ns/10ps

module frontend_map (
   input  umtrx_ctrl_pkg::ctrl_regs_t           regs_i,
   input  logic [umtrx_ctrl_pkg::NUM_DDC-1:0]   run_rx_i,
   input  logic [umtrx_ctrl_pkg::NUM_DUC-1:0]   run_tx_i,
   input  umtrx_ctrl_pkg::dac_pair_t [1:0]      dac_ch_i,
   output umtrx_ctrl_pkg::dac_pair_t [1:0]      dac_o,
   output logic [umtrx_ctrl_pkg::NUM_LEDS-1:0]  leds_o
);
   import umtrx_ctrl_pkg::*;

   logic                led_a;
   logic                led_b;
   logic                led_c;
   logic                led_e;
   logic [NUM_LEDS-1:0] led_hw;

   //////////////////////////////////////////////////////////////////////
   // DAC swap
   always_comb begin
      if (regs_i.tx_fe_sw) begin
         dac_o[0] = dac_ch_i[1];
         dac_o[1] = dac_ch_i[0];
      end else begin
         dac_o[0] = dac_ch_i[0];
         dac_o[1] = dac_ch_i[1];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Hardware LEDs

   // RX activity per frontend
   assign led_c = |(run_rx_i & ~regs_i.rx_fe_sw);
   assign led_b = |(run_rx_i & regs_i.rx_fe_sw);

   // TX LEDs follow the frontend, not the DSP
   assign led_a = regs_i.tx_fe_sw ? run_tx_i[1] : run_tx_i[0];
   assign led_e = regs_i.tx_fe_sw ? run_tx_i[0] : run_tx_i[1];

   assign led_hw = {3'b000, led_a, led_c, led_e, led_b, 1'b0};

   // led_src bit 1 takes hardware, 0 takes software
   assign leds_o = (regs_i.led_src & led_hw) | (~regs_i.led_src & regs_i.led_sw);

endmodule

//--- hw/readback_mux.sv
/*
 * Readback word mux
 * Registers one of 16 status words on each readback request
 */
`timescale 1ns/10ps

module readback_mux (
   input  logic                              wb_clk,
   input  logic                              por_rst,
   input  logic                              rb_req_i,
   input  logic [3:0]                        rb_idx_i,
   input  logic [1:0]                        aux_ld_i,
   input  logic                              button_i,
   output logic [umtrx_ctrl_pkg::WB_DW-1:0]  rb_dat_o
);
   import umtrx_ctrl_pkg::*;

   logic [WB_DW-1:0] irq_word;

   // Lock detects and button in the upper status half
   assign irq_word = {16'b0, aux_ld_i[1], aux_ld_i[0], button_i, 13'b0};

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         rb_dat_o <= '0;
      end else if (rb_req_i) begin
         case (rb_idx_i)
            RB_NUM_DDC: rb_dat_o <= WB_DW'(NUM_DDC);
            RB_NUM_DUC: rb_dat_o <= WB_DW'(NUM_DUC);
            RB_COMPAT:  rb_dat_o <= COMPAT_NUM;
            RB_IRQ:     rb_dat_o <= irq_word;
            // Timer and dropped status words read as zero
            default:    rb_dat_o <= '0;
         endcase
      end
   end

endmodule

//--- hw/setting_reg_bank.sv
/*
 * Settings register bank
 * Holds PA, LMS, LED, PHY reset and switch controls, loaded
 * from settings bus strobes
 */
`timescale 1ns/10ps

module setting_reg_bank (
   input  logic                        wb_clk,
   input  logic                        por_rst,
   input  umtrx_ctrl_pkg::set_bus_t    set_bus_i,
   output umtrx_ctrl_pkg::ctrl_regs_t  regs_o
);
   import umtrx_ctrl_pkg::*;

   logic addr_known;

   // Addresses that hold a register
   always_comb begin
      case (set_bus_i.addr)
         SET_AW'(SR_MISC + 0),
         SET_AW'(SR_MISC + 3),
         SET_AW'(SR_MISC + 4),
         SET_AW'(SR_MISC + 6),
         SET_AW'(SR_DIVSW + 0),
         SET_AW'(SR_DIVSW + 1),
         SET_AW'(SR_RX_FE_SW),
         SET_AW'(SR_TX_FE_SW): addr_known = 1'b1;
         default:             addr_known = 1'b0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Register update
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         regs_o         <= '0;
         regs_o.led_src <= LED_SRC_RESET;
         regs_o.div_sw  <= {2{DIVSW_RESET}};
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            SET_AW'(SR_MISC + 0): begin
               // PA and LMS controls share one word
               regs_o.lms_res    <= set_bus_i.data[1:0];
               regs_o.lowpa      <= set_bus_i.data[2];
               regs_o.enpa1      <= set_bus_i.data[3];
               regs_o.enpa2      <= set_bus_i.data[4];
               regs_o.en_dc_sync <= set_bus_i.data[5];
            end
            SET_AW'(SR_MISC + 3): begin
               regs_o.led_sw <= set_bus_i.data[NUM_LEDS-1:0];
            end
            SET_AW'(SR_MISC + 4): begin
               regs_o.phy_reset <= set_bus_i.data[0];
            end
            SET_AW'(SR_MISC + 6): begin
               // 1 selects the hardware LED source
               regs_o.led_src <= set_bus_i.data[NUM_LEDS-1:0];
            end
            SET_AW'(SR_DIVSW + 0): begin
               regs_o.div_sw[0] <= set_bus_i.data[0];
            end
            SET_AW'(SR_DIVSW + 1): begin
               regs_o.div_sw[1] <= set_bus_i.data[0];
            end
            SET_AW'(SR_RX_FE_SW): begin
               // One frontend select bit per RX DSP
               regs_o.rx_fe_sw <= set_bus_i.data[NUM_DDC-1:0];
            end
            SET_AW'(SR_TX_FE_SW): begin
               regs_o.tx_fe_sw <= set_bus_i.data[0];
            end
            default: begin
               // Unmapped addresses keep every register
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   a_unknown_hold : assert property (
      @(posedge wb_clk) disable iff (por_rst)
      (set_bus_i.stb && !addr_known) |=> $stable(regs_o)
   ) else $error("strobe to unmapped address changed a register");

endmodule

//--- hw/umtrx_ctrl_pkg.sv
/*
 * Transceiver control plane shared definitions
 * Bus widths, settings register map, readback words, window decode
 * constants and the structs carried between the control blocks
 */

package umtrx_ctrl_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   localparam int WB_DW    = 32;
   localparam int WB_AW    = 16;
   localparam int SET_AW   = 8;
   localparam int DAC_W    = 12;
   localparam int NUM_DDC  = 4;
   localparam int NUM_DUC  = 2;
   localparam int NUM_LEDS = 8;

   //////////////////////////////////////////////////////////////////////
   // Settings register map
   localparam int SR_MISC     = 0;
   localparam int SR_DIVSW    = 180;
   localparam int SR_RX_FE_SW = 183;
   localparam int SR_TX_FE_SW = 184;

   // Values loaded at reset
   localparam logic [NUM_LEDS-1:0] LED_SRC_RESET = 8'h1E;
   localparam logic                DIVSW_RESET   = 1'b1;

   // Readback words, compat is major in the upper half
   localparam logic [WB_DW-1:0] COMPAT_NUM = {16'd9, 16'd0};
   localparam logic [3:0]       RB_NUM_DDC = 4'd1;
   localparam logic [3:0]       RB_NUM_DUC = 4'd2;
   localparam logic [3:0]       RB_COMPAT  = 4'd12;
   localparam logic [3:0]       RB_IRQ     = 4'd13;

   // Window decode on the upper address byte
   localparam logic [7:0] SET_WIN_ADDR = 8'h70;
   localparam logic [7:0] SET_WIN_MASK = 8'hF0;
   localparam logic [7:0] RB_WIN_ADDR  = 8'h5C;
   localparam logic [7:0] RB_WIN_MASK  = 8'hFC;

   //////////////////////////////////////////////////////////////////////
   // Structs
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [WB_DW-1:0]  data;
   } set_bus_t;

   typedef struct packed {
      logic [1:0]          lms_res;
      logic                lowpa;
      logic                enpa1;
      logic                enpa2;
      logic                en_dc_sync;
      logic [NUM_LEDS-1:0] led_sw;
      logic [NUM_LEDS-1:0] led_src;
      logic                phy_reset;
      logic [1:0]          div_sw;
      logic [NUM_DDC-1:0]  rx_fe_sw;
      logic                tx_fe_sw;
   } ctrl_regs_t;

   typedef struct packed {
      logic [DAC_W-1:0] a;
      logic [DAC_W-1:0] b;
   } dac_pair_t;

endpackage

//--- hw/umtrx_ctrl_top.sv
/*
 * Transceiver control plane top
 * Wishbone port, settings registers, readback and frontend mapping
 */
`timescale 1ns/10ps

module umtrx_ctrl_top (
   input  logic                                 wb_clk,
   input  logic                                 por_rst,
   input  umtrx_ctrl_pkg::wb_req_t              wb_req_i,
   output logic                                 wb_ack_o,
   output logic [umtrx_ctrl_pkg::WB_DW-1:0]     wb_dat_o,
   input  logic [1:0]                           aux_ld_i,
   input  logic                                 button_i,
   input  logic [umtrx_ctrl_pkg::NUM_DDC-1:0]   run_rx_i,
   input  logic [umtrx_ctrl_pkg::NUM_DUC-1:0]   run_tx_i,
   input  umtrx_ctrl_pkg::dac_pair_t [1:0]      dac_ch_i,
   output umtrx_ctrl_pkg::dac_pair_t [1:0]      dac_o,
   output logic [umtrx_ctrl_pkg::NUM_LEDS-1:0]  leds_o,
   output logic [1:0]                           lms_res_o,
   output logic                                 lowpa_o,
   output logic                                 enpa1_o,
   output logic                                 enpa2_o,
   output logic                                 en_dc_sync_o,
   output logic                                 phy_reset_n_o,
   output logic [1:0]                           div_sw_o,
   output logic [umtrx_ctrl_pkg::NUM_DDC-1:0]   rx_fe_sel_o
);
   import umtrx_ctrl_pkg::*;

   set_bus_t         set_bus;
   ctrl_regs_t       regs;
   logic             rb_req;
   logic [3:0]       rb_idx;
   logic [WB_DW-1:0] rb_dat;

   wb_settings_port u_port (
      .wb_clk    (wb_clk),
      .por_rst   (por_rst),
      .wb_req_i  (wb_req_i),
      .rb_dat_i  (rb_dat),
      .wb_ack_o  (wb_ack_o),
      .wb_dat_o  (wb_dat_o),
      .set_bus_o (set_bus),
      .rb_req_o  (rb_req),
      .rb_idx_o  (rb_idx)
   );

   setting_reg_bank u_regs (
      .wb_clk    (wb_clk),
      .por_rst   (por_rst),
      .set_bus_i (set_bus),
      .regs_o    (regs)
   );

   readback_mux u_rb (
      .wb_clk    (wb_clk),
      .por_rst   (por_rst),
      .rb_req_i  (rb_req),
      .rb_idx_i  (rb_idx),
      .aux_ld_i  (aux_ld_i),
      .button_i  (button_i),
      .rb_dat_o  (rb_dat)
   );

   frontend_map u_fe (
      .regs_i    (regs),
      .run_rx_i  (run_rx_i),
      .run_tx_i  (run_tx_i),
      .dac_ch_i  (dac_ch_i),
      .dac_o     (dac_o),
      .leds_o    (leds_o)
   );

   //////////////////////////////////////////////////////////////////////
   // Register pins
   assign lms_res_o     = regs.lms_res;
   assign lowpa_o       = regs.lowpa;
   assign enpa1_o       = regs.enpa1;
   assign enpa2_o       = regs.enpa2;
   assign en_dc_sync_o  = regs.en_dc_sync;
   // PHY reset pin is active low
   assign phy_reset_n_o = ~regs.phy_reset;
   assign div_sw_o      = regs.div_sw;
   assign rx_fe_sel_o   = regs.rx_fe_sw;

endmodule

//--- hw/wb_settings_port.sv
/*
 * Wishbone slave port for the control plane
 * Decodes the settings and readback windows, acks each access one
 * cycle after it is seen and issues settings strobes
 */
`timescale 1ns/10ps

module wb_settings_port (
   input  logic                              wb_clk,
   input  logic                              por_rst,
   input  umtrx_ctrl_pkg::wb_req_t           wb_req_i,
   input  logic [umtrx_ctrl_pkg::WB_DW-1:0]  rb_dat_i,
   output logic                              wb_ack_o,
   output logic [umtrx_ctrl_pkg::WB_DW-1:0]  wb_dat_o,
   output umtrx_ctrl_pkg::set_bus_t          set_bus_o,
   output logic                              rb_req_o,
   output logic [3:0]                        rb_idx_o
);
   import umtrx_ctrl_pkg::*;

   logic [7:0] win_sel;
   logic       set_win;
   logic       rb_win;
   logic       req_new;
   logic       rb_sel_q;

   //////////////////////////////////////////////////////////////////////
   // Window decode
   assign win_sel = wb_req_i.adr[WB_AW-1:WB_AW-8];
   assign set_win = (win_sel & SET_WIN_MASK) == SET_WIN_ADDR;
   assign rb_win  = (win_sel & RB_WIN_MASK) == RB_WIN_ADDR;

   // No new access in the ack cycle
   assign req_new = wb_req_i.cyc & wb_req_i.stb & ~wb_ack_o;

   // Readback mux registers its word on this same edge
   assign rb_req_o = req_new & ~wb_req_i.we & rb_win;
   assign rb_idx_o = wb_req_i.adr[5:2];

   //////////////////////////////////////////////////////////////////////
   // Ack and strobe
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         wb_ack_o      <= 1'b0;
         set_bus_o.stb <= 1'b0;
         rb_sel_q      <= 1'b0;
      end else begin
         wb_ack_o      <= req_new;
         set_bus_o.stb <= req_new & wb_req_i.we & set_win;
         rb_sel_q      <= rb_req_o;
      end
   end

   // Settings payload, word address of the window
   always_ff @(posedge wb_clk) begin
      if (req_new) begin
         set_bus_o.addr <= wb_req_i.adr[SET_AW+1:2];
         set_bus_o.data <= wb_req_i.dat;
      end
   end

   // Unmapped and write accesses return zero
   assign wb_dat_o = rb_sel_q ? rb_dat_i : '0;

   //////////////////////////////////////////////////////////////////////
   // Checks
   a_ack_single : assert property (
      @(posedge wb_clk) disable iff (por_rst)
      wb_ack_o |=> !wb_ack_o
   ) else $error("ack held for two cycles");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the control plane testbench with Verilator and run it

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_umtrx_ctrl -f verilog.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_umtrx_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
   exit 0
fi
echo "simulation failed, see $LOG"
exit 1

//--- sim/ctrl_patterns.hex
// op addr data expected; expected of a write is the pin word, of a read the data
// op 1 write, 2 read, 3 irq read, 4 output check (data = trials), 5 random write, 0 end
1 7190 ffffffff 000001c0
4 0000 00000008 00000000
1 7000 0000003f 000001ff
1 7000 00000015 000001d5
1 7010 00000001 00000195
1 72d0 00000000 00000115
1 72d4 00000000 00000015
1 72d4 00000001 00000115
1 7010 00000000 00000155
1 72dc 00000005 00000b55
2 5c04 00000000 00000004
2 5c08 00000000 00000002
2 5c30 00000000 00090000
3 5c34 00000000 00000000
3 5c34 00000000 00000000
2 5c14 00000000 00000000
2 1234 00000000 00000000
1 72e0 00000000 00000b55
4 0000 00000008 00000000
1 72e0 00000001 00000b55
4 0000 00000008 00000000
1 7004 ffffffff 00000b55
4 0000 00000008 00000000
5 72dc 00000000 00000000
5 7018 00000000 00000000
5 700c 00000000 00000000
4 0000 00000008 00000000
5 72dc 00000000 00000000
5 7018 00000000 00000000
5 700c 00000000 00000000
5 72e0 00000000 00000000
4 0000 00000008 00000000
0 0000 00000000 00000000

//--- sim/tb_umtrx_ctrl.sv
/*
 * Control plane testbench
 * Replays bus operations from the pattern file and checks pins,
 * readback data, DAC swap and LED mix
 */
`timescale 1ns/10ps

module tb_umtrx_ctrl;
   import umtrx_ctrl_pkg::*;

   logic                wb_clk;
   logic                por_rst;
   wb_req_t             wb_req;
   logic                wb_ack;
   logic [WB_DW-1:0]    wb_dat;
   logic [1:0]          aux_ld;
   logic                button;
   logic [NUM_DDC-1:0]  run_rx;
   logic [NUM_DUC-1:0]  run_tx;
   dac_pair_t [1:0]     dac_ch;
   dac_pair_t [1:0]     dac_out;
   logic [NUM_LEDS-1:0] leds;
   // rx_fe_sel, div_sw, phy_reset_n, en_dc_sync, enpa2, enpa1, lowpa, lms_res
   logic [12:0]         pins;

   logic [31:0] pat_mem [0:255];
   int          num_pat;
   int          cycle_cnt = 0;
   int          cycle_limit = 100000;
   int          checks;
   int          errors;
   logic [15:0] lfsr = 16'd6;

   // Model of the registers behind the LED and DAC outputs
   logic [7:0]  sh_led_sw;
   logic [7:0]  sh_led_src;
   logic [3:0]  sh_rx_fe;
   logic        sh_tx_fe;

   umtrx_ctrl_top u_dut (
      .wb_clk        (wb_clk),
      .por_rst       (por_rst),
      .wb_req_i      (wb_req),
      .wb_ack_o      (wb_ack),
      .wb_dat_o      (wb_dat),
      .aux_ld_i      (aux_ld),
      .button_i      (button),
      .run_rx_i      (run_rx),
      .run_tx_i      (run_tx),
      .dac_ch_i      (dac_ch),
      .dac_o         (dac_out),
      .leds_o        (leds),
      .lms_res_o     (pins[1:0]),
      .lowpa_o       (pins[2]),
      .enpa1_o       (pins[3]),
      .enpa2_o       (pins[4]),
      .en_dc_sync_o  (pins[5]),
      .phy_reset_n_o (pins[6]),
      .div_sw_o      (pins[8:7]),
      .rx_fe_sel_o   (pins[12:9])
   );

   initial begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout after %0d cycles, %0d errors so far", cycle_cnt, errors);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [31:0] pat_word(input int i, input int k);
      return pat_mem[8'(4 * i + k)];
   endfunction

   task automatic compare_val(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      checks++;
      assert (act_v === exp_v) else begin
         errors++;
         $display("error %s: expected %0h, actual %0h", name, exp_v, act_v);
      end
   endtask

   task automatic track_write(input logic [15:0] adr, input logic [31:0] dat);
      if (adr[15:12] == 4'h7) begin
         case (adr[9:2])
            8'd3:    sh_led_sw  = dat[7:0];
            8'd6:    sh_led_src = dat[7:0];
            8'd183:  sh_rx_fe   = dat[3:0];
            8'd184:  sh_tx_fe   = dat[0];
            default: ;
         endcase
      end
   endtask

   // Starts 5 ns after an edge, returns 1 ns after the edge that ends the access
   task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                             input string name, output logic [31:0] rdat);
      int          lat;
      logic [12:0] old_pins;
      old_pins   = pins;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      lat        = 1;
      @(posedge wb_clk);
      #1;
      while (!wb_ack && lat < 4) begin
         @(posedge wb_clk);
         #1;
         lat++;
      end
      rdat = wb_dat;
      assert (wb_ack) else begin
         errors++;
         $display("%s was never acknowledged", name);
      end
      compare_val({name, " ack latency"}, 64'(1), 64'(lat));
      #4;
      wb_req = '0;
      // Registers load on the edge that closes the ack cycle
      compare_val({name, " pins during ack"}, 64'(old_pins), 64'(pins));
      @(posedge wb_clk);
      #1;
      compare_val({name, " ack length"}, 64'(0), 64'(wb_ack));
   endtask

   task automatic run_write(input int idx, input logic [15:0] adr, input logic [31:0] dat,
                            input logic [12:0] exp_pins, input logic rnd);
      string       name;
      logic [31:0] wdat;
      logic [31:0] rdat;
      wdat = rnd ? take_bits(8) : dat;
      name = $sformatf("op %0d write %h", idx, adr);
      bus_access(1'b1, adr, wdat, name, rdat);
      track_write(adr, wdat);
      if (!rnd) begin
         compare_val({name, " pins"}, 64'(exp_pins), 64'(pins));
      end
   endtask

   task automatic run_read(input int idx, input logic [15:0] adr, input logic [31:0] exp_v,
                           input logic irq);
      string       name;
      logic [31:0] rdat;
      logic [31:0] want;
      want = exp_v;
      if (irq) begin
         aux_ld = 2'(take_bits(2));
         button = 1'(take_bits(1));
         want   = {16'h0000, aux_ld, button, 13'h0000};
      end
      name = $sformatf("op %0d read %h", idx, adr);
      bus_access(1'b0, adr, 32'h0, name, rdat);
      compare_val({name, " data"}, 64'(want), 64'(rdat));
   endtask

   task automatic check_outputs(input int idx, input int trials);
      string       name;
      logic [7:0]  hw;
      logic [47:0] exp_dac;
      for (int t = 0; t < trials; t++) begin
         if (t > 0) begin
            #4;
         end
         run_rx      = 4'(take_bits(4));
         run_tx      = 2'(take_bits(2));
         dac_ch[0].a = 12'(take_bits(12));
         dac_ch[0].b = 12'(take_bits(12));
         dac_ch[1].a = 12'(take_bits(12));
         dac_ch[1].b = 12'(take_bits(12));
         @(posedge wb_clk);
         #1;
         // LEDC and LEDB per RX frontend, LEDA and LEDE follow the TX switch
         hw      = 8'h00;
         hw[3]   = |(run_rx & ~sh_rx_fe);
         hw[1]   = |(run_rx & sh_rx_fe);
         hw[4]   = sh_tx_fe ? run_tx[1] : run_tx[0];
         hw[2]   = sh_tx_fe ? run_tx[0] : run_tx[1];
         exp_dac = sh_tx_fe ? {dac_ch[0], dac_ch[1]} : dac_ch;
         name    = $sformatf("op %0d trial %0d", idx, t);
         compare_val({name, " dac"}, 64'(exp_dac), 64'(dac_out));
         compare_val({name, " leds"}, 64'((sh_led_src & hw) | (~sh_led_src & sh_led_sw)),
                     64'(leds));
         compare_val({name, " rx_fe_sel"}, 64'(sh_rx_fe), 64'(pins[12:9]));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      logic [3:0]  op;
      logic [15:0] adr;
      logic [31:0] dat;
      logic [31:0] exp_v;
      num_pat    = 0;
      checks     = 0;
      errors     = 0;
      por_rst    = 1'b1;
      wb_req     = '0;
      aux_ld     = 2'b00;
      button     = 1'b0;
      run_rx     = '0;
      run_tx     = '0;
      dac_ch     = '0;
      sh_led_sw  = 8'h00;
      sh_led_src = 8'h1E;
      sh_rx_fe   = 4'h0;
      sh_tx_fe   = 1'b0;
      $readmemh("sim/ctrl_patterns.hex", pat_mem);
      while (num_pat < 64 && pat_word(num_pat, 0) != 32'h0) begin
         num_pat++;
      end
      cycle_limit = 10 * num_pat + 200;
      assert (num_pat > 0) else begin
         errors++;
         $display("no operations could be read from the pattern file");
      end
      repeat (10) @(posedge wb_clk);
      #5;
      por_rst = 1'b0;
      for (int i = 0; i < num_pat; i++) begin
         op    = 4'(pat_word(i, 0));
         adr   = 16'(pat_word(i, 1));
         dat   = pat_word(i, 2);
         exp_v = pat_word(i, 3);
         case (op)
            4'd1:    run_write(i, adr, dat, exp_v[12:0], 1'b0);
            4'd2:    run_read(i, adr, exp_v, 1'b0);
            4'd3:    run_read(i, adr, exp_v, 1'b1);
            4'd4:    check_outputs(i, int'(dat[7:0]));
            4'd5:    run_write(i, adr, dat, exp_v[12:0], 1'b1);
            default: begin
               errors++;
               $display("operation %0d has unknown op code %0h", i, op);
               @(posedge wb_clk);
               #1;
            end
         endcase
         #4;
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- verilog.f
hw/umtrx_ctrl_pkg.sv
hw/wb_settings_port.sv
hw/setting_reg_bank.sv
hw/readback_mux.sv
hw/frontend_map.sv
hw/umtrx_ctrl_top.sv
sim/tb_umtrx_ctrl.sv
